// File: verilog/cache_pkg.sv
// Cache sizes, address field types, line word helpers and controller state encoding
`default_nettype none

package cache_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Word addressed processor and memory
  localparam int addr_w = 32;
  localparam int word_w = 32;
  localparam int line_words = 4;

  // Address split is tag | index | offset
  localparam int offset_w = $clog2(line_words);
  localparam int index_w = 4;
  localparam int tag_w = addr_w - index_w - offset_w;
  localparam int line_count = 1 << index_w;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [word_w-1:0] word_t;
  // Word 0 sits in the low bits
  typedef logic [line_words*word_w-1:0] line_t;
  typedef logic [tag_w-1:0] tag_t;
  typedef logic [index_w-1:0] index_t;
  typedef logic [offset_w-1:0] offset_t;

  // Main controller states
  typedef enum logic [1:0] {
    idle,
    tag_cmp,
    write_back,
    read_mem
  } ctrl_state_t;

  // One word out of a line
  function automatic word_t pick_word(input line_t line, input offset_t off);
    return line[off*word_w +: word_w];
  endfunction

  // Line with one word replaced
  function automatic line_t merge_word(input line_t line, input offset_t off, input word_t word);
    line_t merged;
    merged = line;
    merged[off*word_w +: word_w] = word;
    return merged;
  endfunction

endpackage

`default_nettype wire

// File: verilog/tag_store.sv
// Tag and valid array with registered hit compare and victim line address
`default_nettype none
`timescale 1ns/100ps

module tag_store (
  input  logic               clk,
  input  logic               reset,
  input  logic               en,
  // 0 lookup, 1 store tag and set valid
  input  logic               write,
  input  cache_pkg::addr_t   addr,
  output logic               done,
  output logic               hit,
  output cache_pkg::addr_t   victim_addr
);

  // One tag and one valid bit per line
  cache_pkg::tag_t                  tags [cache_pkg::line_count];
  logic [cache_pkg::line_count-1:0] valid;

  // Fields of the incoming address
  cache_pkg::index_t idx;
  cache_pkg::tag_t   tag_in;

  assign idx    = addr[cache_pkg::offset_w+cache_pkg::index_w-1:cache_pkg::offset_w];
  assign tag_in = addr[cache_pkg::addr_w-1:cache_pkg::offset_w+cache_pkg::index_w];

  //////////////////////////////////////////////////
  // Status and valid bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      valid <= '0;
      done  <= 1'b0;
      hit   <= 1'b0;
    end else begin
      // Only lookups report back
      done <= en && !write;
      if (en && write) begin
        valid[idx] <= 1'b1;
      end
      if (en && !write) begin
        hit <= valid[idx] && (tags[idx] == tag_in);
      end
    end
  end

  //////////////////////////////////////////////////
  // Tag array and victim address
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (en && write) begin
      tags[idx] <= tag_in;
    end
    // Line address of whatever currently sits at this index
    if (en && !write) begin
      victim_addr <= {tags[idx], idx, {cache_pkg::offset_w{1'b0}}};
    end
  end

  // Done always answers a lookup one cycle earlier
  done_after_read: assert property (@(posedge clk) disable iff (!reset)
    $rose(done) |-> $past(en && !write));

endmodule

`default_nettype wire

// File: verilog/line_store.sv
// Line data array with dirty bits, full line and single word writes, registered reads
`default_nettype none
`timescale 1ns/100ps

module line_store (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 en,
  // 0 read, 1 write
  input  logic                 write,
  // Only the word chosen by offset is replaced
  input  logic                 word_write,
  // Dirty bit value loaded by any write
  input  logic                 set_dirty,
  input  cache_pkg::index_t    index,
  input  cache_pkg::offset_t   offset,
  input  cache_pkg::line_t     wdata,
  input  cache_pkg::word_t     word_wdata,
  output logic                 rdy,
  output logic                 dirty,
  output cache_pkg::line_t     rdata
);

  // Line contents and per line dirty flags
  cache_pkg::line_t                 lines [cache_pkg::line_count];
  logic [cache_pkg::line_count-1:0] dirty_bits;

  //////////////////////////////////////////////////
  // Dirty bits and read status
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      dirty_bits <= '0;
      rdy        <= 1'b0;
      dirty      <= 1'b0;
    end else begin
      rdy <= en && !write;
      if (en && write) begin
        dirty_bits[index] <= set_dirty;
      end
      if (en && !write) begin
        dirty <= dirty_bits[index];
      end
    end
  end

  //////////////////////////////////////////////////
  // Data array
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (en && write) begin
      if (word_write) begin
        lines[index] <= cache_pkg::merge_word(lines[index], offset, word_wdata);
      end else begin
        // Refill replaces the whole line
        lines[index] <= wdata;
      end
    end
    if (en && !write) begin
      rdata <= lines[index];
    end
  end

  // Word write is a qualifier of a write, never a command of its own
  word_write_needs_write: assert property (@(posedge clk) disable iff (!reset)
    word_write |-> write);

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
// Main cache controller FSM: lookup, hit service, victim write-back, line refill
`default_nettype none
`timescale 1ns/100ps

module cache_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  // Processor side
  input  logic                  access,
  input  logic                  rdwr,
  input  cache_pkg::addr_t      addr,
  input  cache_pkg::word_t      wdata,
  output logic                  gnt,
  output logic                  busy,
  output logic                  rdy,
  output logic                  hit,
  output cache_pkg::word_t      rdata,
  // External memory side
  output logic                  ext_en,
  output logic                  ext_rdwr,
  output cache_pkg::addr_t      ext_addr,
  output cache_pkg::line_t      ext_wdata,
  input  cache_pkg::line_t      ext_rdata,
  input  logic                  ext_rdy,
  input  logic                  ext_wrrdy,
  // Tag store
  output logic                  tag_en,
  output logic                  tag_write,
  output cache_pkg::addr_t      tag_addr,
  input  logic                  tag_done,
  input  logic                  tag_hit,
  input  cache_pkg::addr_t      victim_addr,
  // Line store
  output logic                  line_en,
  output logic                  line_write,
  output logic                  word_write,
  output logic                  set_dirty,
  output cache_pkg::index_t     line_index,
  output cache_pkg::offset_t    line_offset,
  output cache_pkg::line_t      line_wdata,
  output cache_pkg::word_t      word_wdata,
  input  cache_pkg::line_t      line_rdata,
  input  logic                  line_rdy,
  input  logic                  line_dirty
);

  cache_pkg::ctrl_state_t state;

  // Request held for the whole operation
  logic                op_rdwr;
  cache_pkg::addr_t    op_addr;
  cache_pkg::word_t    op_wdata;

  // Line address of the request, offset forced to 0
  cache_pkg::addr_t    fill_addr;

  // State exits
  logic start;
  logic lookup_done;
  logic wb_done;
  logic fill_done;

  assign fill_addr = {op_addr[cache_pkg::addr_w-1:cache_pkg::offset_w],
                      {cache_pkg::offset_w{1'b0}}};

  assign start       = (state == cache_pkg::idle) && access;
  assign lookup_done = (state == cache_pkg::tag_cmp) && tag_done && line_rdy;
  assign wb_done     = (state == cache_pkg::write_back) && ext_wrrdy;
  assign fill_done   = (state == cache_pkg::read_mem) && ext_rdy;

  // Store addressing comes straight from the held request
  assign tag_addr    = op_addr;
  assign line_index  = op_addr[cache_pkg::offset_w+cache_pkg::index_w-1:cache_pkg::offset_w];
  assign line_offset = op_addr[cache_pkg::offset_w-1:0];
  assign word_wdata  = op_wdata;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state      <= cache_pkg::idle;
      gnt        <= 1'b0;
      busy       <= 1'b0;
      rdy        <= 1'b0;
      hit        <= 1'b0;
      ext_en     <= 1'b0;
      ext_rdwr   <= 1'b0;
      tag_en     <= 1'b0;
      tag_write  <= 1'b0;
      line_en    <= 1'b0;
      line_write <= 1'b0;
      word_write <= 1'b0;
      set_dirty  <= 1'b0;
    end else begin
      // Strobes last one cycle unless a state raises them again
      gnt     <= 1'b0;
      rdy     <= 1'b0;
      ext_en  <= 1'b0;
      tag_en  <= 1'b0;
      line_en <= 1'b0;
      case (state)
        cache_pkg::idle: begin
          // Any write issued on the way out has been sampled by now
          tag_write  <= 1'b0;
          line_write <= 1'b0;
          word_write <= 1'b0;
          set_dirty  <= 1'b0;
          if (access) begin
            gnt     <= 1'b1;
            busy    <= 1'b1;
            // Tag and line lookups run side by side
            tag_en  <= 1'b1;
            line_en <= 1'b1;
            state   <= cache_pkg::tag_cmp;
          end
        end
        cache_pkg::tag_cmp: begin
          if (tag_done && line_rdy) begin
            hit <= tag_hit;
            if (tag_hit && !op_rdwr) begin
              // Read hit, word picked in the payload block
              rdy   <= 1'b1;
              busy  <= 1'b0;
              state <= cache_pkg::idle;
            end else if (tag_hit) begin
              // Write hit, single word into the line, line goes dirty
              line_en    <= 1'b1;
              line_write <= 1'b1;
              word_write <= 1'b1;
              set_dirty  <= 1'b1;
              busy       <= 1'b0;
              state      <= cache_pkg::idle;
            end else if (line_dirty) begin
              // Victim must reach memory before the refill
              ext_en   <= 1'b1;
              ext_rdwr <= 1'b1;
              state    <= cache_pkg::write_back;
            end else begin
              ext_en   <= 1'b1;
              ext_rdwr <= 1'b0;
              state    <= cache_pkg::read_mem;
            end
          end
        end
        cache_pkg::write_back: begin
          if (ext_wrrdy) begin
            ext_en   <= 1'b1;
            ext_rdwr <= 1'b0;
            state    <= cache_pkg::read_mem;
          end
        end
        cache_pkg::read_mem: begin
          if (ext_rdy) begin
            // New tag and full line in the same cycle
            tag_en     <= 1'b1;
            tag_write  <= 1'b1;
            line_en    <= 1'b1;
            line_write <= 1'b1;
            word_write <= 1'b0;
            // Merged write miss leaves the line dirty
            set_dirty  <= op_rdwr;
            rdy        <= !op_rdwr;
            busy       <= 1'b0;
            state      <= cache_pkg::idle;
          end
        end
        default: state <= cache_pkg::idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Request and data registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (start) begin
      op_rdwr  <= rdwr;
      op_addr  <= addr;
      op_wdata <= wdata;
    end
    if (lookup_done) begin
      rdata     <= cache_pkg::pick_word(line_rdata, line_offset);
      ext_wdata <= line_rdata;
      ext_addr  <= (!tag_hit && line_dirty) ? victim_addr : fill_addr;
    end
    // Refill address after the victim is out
    if (wb_done) begin
      ext_addr <= fill_addr;
    end
    if (fill_done) begin
      rdata      <= cache_pkg::pick_word(ext_rdata, line_offset);
      line_wdata <= op_rdwr ? cache_pkg::merge_word(ext_rdata, line_offset, op_wdata)
                            : ext_rdata;
    end
  end

  // Grant is a single cycle pulse
  gnt_one_cycle: assert property (@(posedge clk) disable iff (!reset)
    gnt |=> !gnt);

  // Read data ready only when the operation ends
  rdy_ends_busy: assert property (@(posedge clk) disable iff (!reset)
    rdy |-> $fell(busy));

  // No memory traffic outside an operation
  ext_en_in_busy: assert property (@(posedge clk) disable iff (!reset)
    ext_en |-> busy);

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
// Cache top level: main controller, tag store and line store
`default_nettype none
`timescale 1ns/100ps

module cache_top (
  input  logic               clk,
  input  logic               reset,
  // Processor side
  input  logic               access,
  input  logic               rdwr,
  input  cache_pkg::addr_t   addr,
  input  cache_pkg::word_t   wdata,
  output logic               gnt,
  output logic               busy,
  output logic               rdy,
  output logic               hit,
  output cache_pkg::word_t   rdata,
  // External memory side
  output logic               ext_en,
  output logic               ext_rdwr,
  output cache_pkg::addr_t   ext_addr,
  output cache_pkg::line_t   ext_wdata,
  input  cache_pkg::line_t   ext_rdata,
  input  logic               ext_rdy,
  input  logic               ext_wrrdy
);

  //////////////////////////////////////////////////
  // Controller to tag store
  //////////////////////////////////////////////////

  logic               tag_en;
  logic               tag_write;
  cache_pkg::addr_t   tag_addr;
  logic               tag_done;
  logic               tag_hit;
  cache_pkg::addr_t   victim_addr;

  //////////////////////////////////////////////////
  // Controller to line store
  //////////////////////////////////////////////////

  logic               line_en;
  logic               line_write;
  logic               word_write;
  logic               set_dirty;
  cache_pkg::index_t  line_index;
  cache_pkg::offset_t line_offset;
  cache_pkg::line_t   line_wdata;
  cache_pkg::word_t   word_wdata;
  cache_pkg::line_t   line_rdata;
  logic               line_rdy;
  logic               line_dirty;

  cache_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .access      (access),
    .rdwr        (rdwr),
    .addr        (addr),
    .wdata       (wdata),
    .gnt         (gnt),
    .busy        (busy),
    .rdy         (rdy),
    .hit         (hit),
    .rdata       (rdata),
    .ext_en      (ext_en),
    .ext_rdwr    (ext_rdwr),
    .ext_addr    (ext_addr),
    .ext_wdata   (ext_wdata),
    .ext_rdata   (ext_rdata),
    .ext_rdy     (ext_rdy),
    .ext_wrrdy   (ext_wrrdy),
    .tag_en      (tag_en),
    .tag_write   (tag_write),
    .tag_addr    (tag_addr),
    .tag_done    (tag_done),
    .tag_hit     (tag_hit),
    .victim_addr (victim_addr),
    .line_en     (line_en),
    .line_write  (line_write),
    .word_write  (word_write),
    .set_dirty   (set_dirty),
    .line_index  (line_index),
    .line_offset (line_offset),
    .line_wdata  (line_wdata),
    .word_wdata  (word_wdata),
    .line_rdata  (line_rdata),
    .line_rdy    (line_rdy),
    .line_dirty  (line_dirty)
  );

  // Tags and valid bits, one per line
  tag_store u_tags (
    .clk         (clk),
    .reset       (reset),
    .en          (tag_en),
    .write       (tag_write),
    .addr        (tag_addr),
    .done        (tag_done),
    .hit         (tag_hit),
    .victim_addr (victim_addr)
  );

  // Line data and dirty bits
  line_store u_lines (
    .clk        (clk),
    .reset      (reset),
    .en         (line_en),
    .write      (line_write),
    .word_write (word_write),
    .set_dirty  (set_dirty),
    .index      (line_index),
    .offset     (line_offset),
    .wdata      (line_wdata),
    .word_wdata (word_wdata),
    .rdy        (line_rdy),
    .dirty      (line_dirty),
    .rdata      (line_rdata)
  );

endmodule

`default_nettype wire

// File: tb/ext_mem_model.sv
// External memory model: fixed response latency, line reads and writes, address based content rule
`default_nettype none
`timescale 1ns/100ps

module ext_mem_model (
  input  logic               clk,
  input  logic               reset,
  input  logic               en,
  // 0 read, 1 write
  input  logic               rdwr,
  input  cache_pkg::addr_t   addr,
  input  cache_pkg::line_t   wdata,
  output cache_pkg::line_t   rdata,
  output logic               rdy,
  output logic               wrrdy
);

  // Cycles from the sampled enable to the answer
  localparam int latency = 3;

  // Only words that were written back are stored
  cache_pkg::word_t mem [cache_pkg::addr_t];

  // Pending request
  int               count;
  int               w;
  logic             op_rdwr;
  cache_pkg::addr_t op_addr;
  cache_pkg::line_t op_wdata;

  // Unwritten words follow the address pattern
  function automatic cache_pkg::word_t read_word(input cache_pkg::addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ 32'h5a5a_0000;
  endfunction

  //////////////////////////////////////////////////
  // Request timer and response
  //////////////////////////////////////////////////

  always @(posedge clk or negedge reset) begin
    if (!reset) begin
      count <= 0;
      rdy   <= 1'b0;
      wrrdy <= 1'b0;
      rdata <= '0;
    end else begin
      rdy   <= 1'b0;
      wrrdy <= 1'b0;
      if (en) begin
        count    <= latency;
        op_rdwr  <= rdwr;
        op_addr  <= addr;
        op_wdata <= wdata;
      end else if (count != 0) begin
        count <= count - 1;
        // Last cycle of the wait answers the request
        if (count == 1) begin
          if (op_rdwr) begin
            for (w = 0; w < 4; w++) begin
              mem[op_addr + w] = op_wdata[w*32 +: 32];
            end
            wrrdy <= 1'b1;
          end else begin
            for (w = 0; w < 4; w++) begin
              rdata[w*32 +: 32] <= read_word(op_addr + w);
            end
            rdy <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_cache.sv
// Cache testbench: clock and reset, shadow memory and tag table, directed tests, final report
`default_nettype none
`timescale 1ns/100ps

module tb_cache;

  // Edges allowed for any single wait
  localparam int wait_limit = 200;
  // Content of unwritten memory words is the address with this mask
  localparam logic [31:0] mem_mask = 32'h5a5a_0000;

  logic               clk;
  logic               reset;
  logic               access;
  logic               rdwr;
  cache_pkg::addr_t   addr;
  cache_pkg::word_t   wdata;
  logic               gnt;
  logic               busy;
  logic               rdy;
  logic               hit;
  cache_pkg::word_t   rdata;
  logic               ext_en;
  logic               ext_rdwr;
  cache_pkg::addr_t   ext_addr;
  cache_pkg::line_t   ext_wdata;
  cache_pkg::line_t   ext_rdata;
  logic               ext_rdy;
  logic               ext_wrrdy;

  // Shadow memory and shadow tag table
  cache_pkg::word_t   shadow_mem [cache_pkg::addr_t];
  logic               sh_valid [16];
  logic [25:0]        sh_tag [16];
  logic               sh_dirty [16];

  // External requests seen since the last access
  logic               ext_rdwr_q [$];
  cache_pkg::addr_t   ext_addr_q [$];
  cache_pkg::line_t   ext_data_q [$];
  int                 ext_count;
  int                 ext_write_count;

  // Results of the last access
  cache_pkg::word_t   last_rdata;
  logic               last_hit;
  int                 last_edges;

  int                 error_count;
  int                 access_count;
  logic [31:0]        rnd;

  cache_top dut (
    .clk       (clk),
    .reset     (reset),
    .access    (access),
    .rdwr      (rdwr),
    .addr      (addr),
    .wdata     (wdata),
    .gnt       (gnt),
    .busy      (busy),
    .rdy       (rdy),
    .hit       (hit),
    .rdata     (rdata),
    .ext_en    (ext_en),
    .ext_rdwr  (ext_rdwr),
    .ext_addr  (ext_addr),
    .ext_wdata (ext_wdata),
    .ext_rdata (ext_rdata),
    .ext_rdy   (ext_rdy),
    .ext_wrrdy (ext_wrrdy)
  );

  ext_mem_model u_mem (
    .clk   (clk),
    .reset (reset),
    .en    (ext_en),
    .rdwr  (ext_rdwr),
    .addr  (ext_addr),
    .wdata (ext_wdata),
    .rdata (ext_rdata),
    .rdy   (ext_rdy),
    .wrrdy (ext_wrrdy)
  );

  always #4 clk = ~clk;

  // External bus watched in mid cycle
  always @(negedge clk) begin
    if (reset && ext_en) begin
      ext_rdwr_q.push_back(ext_rdwr);
      ext_addr_q.push_back(ext_addr);
      ext_data_q.push_back(ext_wdata);
      ext_count++;
      if (ext_rdwr) begin
        ext_write_count++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    error_count++;
    $display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
  endtask

  task automatic report_fault(input string what);
    error_count++;
    $display("at %0t ns: %s", $time, what);
  endtask

  task automatic finish_run();
    $display("accesses %0d, errors %0d", access_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    report_fault(what);
    finish_run();
  endtask

  //////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////

  // Coherent content of one word address
  function automatic cache_pkg::word_t expect_word(input cache_pkg::addr_t a);
    if (shadow_mem.exists(a)) begin
      return shadow_mem[a];
    end
    return a ^ mem_mask;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////////////////////////////////
  // One processor access with all generic checks
  //////////////////////////////////////////////////

  task automatic cache_op(input logic wr, input cache_pkg::addr_t a, input cache_pkg::word_t d);
    logic [3:0]       idx;
    logic [25:0]      tg;
    logic             exp_hit;
    logic             exp_wb;
    int               exp_reqs;
    cache_pkg::addr_t victim;
    cache_pkg::addr_t line_a;
    cache_pkg::word_t exp_data;
    int               n;
    int               edges;
    int               i;
    idx      = a[5:2];
    tg       = a[31:6];
    exp_hit  = sh_valid[idx] && (sh_tag[idx] == tg);
    exp_wb   = !exp_hit && sh_valid[idx] && sh_dirty[idx];
    exp_reqs = exp_hit ? 0 : (exp_wb ? 2 : 1);
    victim   = {sh_tag[idx], idx, 2'b00};
    line_a   = {a[31:2], 2'b00};
    exp_data = expect_word(a);
    access_count++;
    access = 1'b1;
    rdwr   = wr;
    addr   = a;
    wdata  = d;
    // Request held until the grant
    n = 0;
    @(posedge clk);
    #1;
    while (!gnt && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!gnt) begin
      abort_on_timeout("the cache never granted the access");
    end
    access = 1'b0;
    // End of the operation is the fall of busy
    edges = 0;
    while (busy && edges < wait_limit) begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (busy) begin
      abort_on_timeout("busy never fell after the grant");
    end
    last_rdata = rdata;
    last_hit   = hit;
    last_edges = edges;
    assert (hit === exp_hit) else report_value("hit", exp_hit, hit);
    if (exp_hit) begin
      assert (edges == 2) else report_value("busy fall edge", 2, edges);
    end
    if (!wr) begin
      assert (rdy === 1'b1) else report_fault("rdy did not pulse with the fall of busy");
      assert (rdata === exp_data) else report_value("rdata", exp_data, rdata);
    end else begin
      assert (rdy === 1'b0) else report_fault("rdy pulsed at the end of a write");
    end
    //////////////////////////////////////////////////
    // External traffic of this access
    //////////////////////////////////////////////////
    assert (ext_addr_q.size() == exp_reqs)
      else report_value("ext_en pulses", exp_reqs, ext_addr_q.size());
    if (exp_wb && ext_addr_q.size() == 2) begin
      assert (ext_rdwr_q[0] === 1'b1) else report_value("ext_rdwr", 1, ext_rdwr_q[0]);
      assert (ext_addr_q[0] === victim) else report_value("ext_addr", victim, ext_addr_q[0]);
      for (i = 0; i < 4; i++) begin
        assert (ext_data_q[0][i*32 +: 32] === expect_word(victim + i))
          else report_value("ext_wdata", expect_word(victim + i), ext_data_q[0][i*32 +: 32]);
      end
      assert (ext_rdwr_q[1] === 1'b0) else report_value("ext_rdwr", 0, ext_rdwr_q[1]);
      assert (ext_addr_q[1] === line_a) else report_value("ext_addr", line_a, ext_addr_q[1]);
    end else if (!exp_hit && ext_addr_q.size() == 1) begin
      assert (ext_rdwr_q[0] === 1'b0) else report_value("ext_rdwr", 0, ext_rdwr_q[0]);
      assert (ext_addr_q[0] === line_a) else report_value("ext_addr", line_a, ext_addr_q[0]);
    end
    ext_rdwr_q.delete();
    ext_addr_q.delete();
    ext_data_q.delete();
    // Shadow state after the access
    if (wr) begin
      shadow_mem[a] = d;
    end
    if (!exp_hit) begin
      sh_valid[idx] = 1'b1;
      sh_tag[idx]   = tg;
      sh_dirty[idx] = wr;
    end else if (wr) begin
      sh_dirty[idx] = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic check_reset_state();
    assert (gnt === 1'b0) else report_value("gnt", 0, gnt);
    assert (busy === 1'b0) else report_value("busy", 0, busy);
    assert (rdy === 1'b0) else report_value("rdy", 0, rdy);
    assert (ext_en === 1'b0) else report_value("ext_en", 0, ext_en);
  endtask

  task automatic cold_read_test();
    cache_op(1'b0, 32'h0001_0046, '0);
    assert (last_hit === 1'b0) else report_value("hit", 0, last_hit);
    assert (last_rdata === (32'h0001_0046 ^ mem_mask))
      else report_value("rdata", 32'h0001_0046 ^ mem_mask, last_rdata);
  endtask

  task automatic same_line_hit_test();
    cache_op(1'b0, 32'h0001_0045, '0);
    assert (last_hit === 1'b1) else report_value("hit", 1, last_hit);
    assert (last_edges == 2) else report_value("busy fall edge", 2, last_edges);
  endtask

  task automatic write_hit_test();
    int ext_start;
    ext_start = ext_count;
    cache_op(1'b1, 32'h0001_0047, 32'hc0de_0001);
    cache_op(1'b0, 32'h0001_0047, '0);
    assert (last_hit === 1'b1) else report_value("hit", 1, last_hit);
    assert (last_rdata === 32'hc0de_0001) else report_value("rdata", 32'hc0de_0001, last_rdata);
    assert (ext_count == ext_start) else report_fault("a write hit reached external memory");
  endtask

  task automatic write_miss_test();
    cache_op(1'b1, 32'h0002_0089, 32'h1234_abcd);
    assert (last_hit === 1'b0) else report_value("hit", 0, last_hit);
    cache_op(1'b0, 32'h0002_0088, '0);
    assert (last_rdata === (32'h0002_0088 ^ mem_mask))
      else report_value("rdata", 32'h0002_0088 ^ mem_mask, last_rdata);
    cache_op(1'b0, 32'h0002_008a, '0);
    cache_op(1'b0, 32'h0002_008b, '0);
    cache_op(1'b0, 32'h0002_0089, '0);
    assert (last_rdata === 32'h1234_abcd) else report_value("rdata", 32'h1234_abcd, last_rdata);
  endtask

  task automatic dirty_evict_test();
    int writes_start;
    // Lines A and B share index 4
    cache_op(1'b1, 32'h0003_00d3, 32'hfeed_0a0a);
    writes_start = ext_write_count;
    cache_op(1'b0, 32'h0007_00d1, '0);
    assert (ext_write_count == writes_start + 1)
      else report_fault("reading line B did not write line A back");
    cache_op(1'b0, 32'h0003_00d3, '0);
    assert (last_hit === 1'b0) else report_value("hit", 0, last_hit);
    assert (last_rdata === 32'hfeed_0a0a) else report_value("rdata", 32'hfeed_0a0a, last_rdata);
  endtask

  task automatic random_test();
    int          k;
    logic [25:0] tg;
    logic        wr;
    logic [31:0] a;
    for (k = 0; k < 200; k++) begin
      rnd = xorshift(rnd);
      // Three tags per index force conflicts
      tg  = 26'h00_2a00 + (rnd[15:0] % 3);
      wr  = rnd[16];
      a   = {tg, rnd[5:2], rnd[7:6]};
      rnd = xorshift(rnd);
      cache_op(wr, a, rnd);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk             = 1'b0;
    reset           = 1'b0;
    access          = 1'b0;
    rdwr            = 1'b0;
    addr            = '0;
    wdata           = '0;
    error_count     = 0;
    access_count    = 0;
    ext_count       = 0;
    ext_write_count = 0;
    rnd             = 32'ha4f3_0dc3;
    for (int i = 0; i < 16; i++) begin
      sh_valid[i] = 1'b0;
      sh_tag[i]   = '0;
      sh_dirty[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b1;
    @(posedge clk);
    #1;
    check_reset_state();
    cold_read_test();
    same_line_hit_test();
    write_hit_test();
    write_miss_test();
    dirty_evict_test();
    random_test();
    finish_run();
  end

endmodule

`default_nettype wire

// File: all.f
verilog/cache_pkg.sv
verilog/tag_store.sv
verilog/line_store.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tb/ext_mem_model.sv
tb/tb_cache.sv
